//--- src/cache_settings.svh
// ********************
// geometry assumes one 32-bit word per line and a power-of-two way count.
// ********************
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry.
`define L2_WAYS      4
`define L2_SETS      16
`define L2_SET_BITS  4
`define L2_WAY_BITS  2

// tag covers the address above the set index and byte offset.
`define L2_TAG_BITS  26

// line state codes.
`define INVALID      2'b00
`define VALID        2'b01
`define DIRTY        2'b10

`endif

//--- src/cache_pkg.sv
// ********************
// widths follow cache_settings.svh.
// ********************
`include "cache_settings.svh"

package cache_pkg;

    typedef logic [31:0] l2_addr_t;
    typedef logic [31:0] l2_word_t;

    typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;
    typedef logic [`L2_SET_BITS-1:0] l2_set_t;
    typedef logic [`L2_WAY_BITS-1:0] l2_way_t;

    // holds one of the INVALID, VALID or DIRTY codes.
    typedef logic [1:0] line_state_t;

    typedef enum logic [2:0] {
        idle,
        read_set,
        lookup,
        decide,
        write_back,
        fill,
        respond
    } ctrl_state_t;

endpackage

//--- src/l2_tag_store.sv
// ********************
// tags are not reset; only states and pointers are.
// ********************
`timescale 1ns/1ns
`include "cache_settings.svh"

module l2_tag_store (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_en,
    input  cache_pkg::l2_set_t     rd_set,
    input  logic                   wr_en,
    input  cache_pkg::l2_set_t     wr_set,
    input  cache_pkg::l2_way_t     wr_way,
    input  cache_pkg::l2_tag_t     wr_tag,
    input  cache_pkg::line_state_t wr_state,
    input  logic                   advance_ptr,
    output cache_pkg::l2_tag_t     tags_buf [`L2_WAYS],
    output cache_pkg::line_state_t states_buf [`L2_WAYS],
    output cache_pkg::l2_way_t     evict_way_buf
);

    cache_pkg::l2_tag_t     tags [`L2_SETS][`L2_WAYS];
    cache_pkg::line_state_t states [`L2_SETS][`L2_WAYS];
    cache_pkg::l2_way_t     rr_ptr [`L2_SETS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_set][wr_way] <= wr_tag;
        end
        if (rd_en) begin
            tags_buf <= tags[rd_set];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                rr_ptr[s] <= '0;
                for (int w = 0; w < `L2_WAYS; w++) begin
                    states[s][w] <= `INVALID;
                end
            end
            states_buf    <= '{default: `INVALID};
            evict_way_buf <= '0;
        end else begin
            if (wr_en) begin
                states[wr_set][wr_way] <= wr_state;
            end
            // pointer wraps at the way count.
            if (wr_en && advance_ptr) begin
                rr_ptr[wr_set] <= rr_ptr[wr_set] + 1'b1;
            end
            if (rd_en) begin
                states_buf    <= states[rd_set];
                evict_way_buf <= rr_ptr[rd_set];
            end
        end
    end

    state_code_ok: assert property (@(posedge clk) disable iff (!rst)
        wr_en |-> wr_state inside {`INVALID, `VALID, `DIRTY})
        else $error("undefined line state written");

endmodule

//--- src/l2_data_store.sv
// ********************
// full-word writes only.
// ********************
`timescale 1ns/1ns
`include "cache_settings.svh"

module l2_data_store (
    input  logic               clk,
    input  logic               rd_en,
    input  cache_pkg::l2_set_t rd_set,
    input  logic               wr_en,
    input  cache_pkg::l2_set_t wr_set,
    input  cache_pkg::l2_way_t wr_way,
    input  cache_pkg::l2_word_t wr_data,
    output cache_pkg::l2_word_t data_buf [`L2_WAYS]
);

    cache_pkg::l2_word_t lines [`L2_SETS][`L2_WAYS];

    // one word per way.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            lines[wr_set][wr_way] <= wr_data;
        end
    end

    // whole set is read so the hit way can be picked after lookup.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_buf <= lines[rd_set];
        end
    end

endmodule

//--- src/l2_lookup.sv
// ********************
// results hold while lookup_en is low.
// ********************
`timescale 1ns/1ns
`include "cache_settings.svh"

module l2_lookup (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   lookup_en,
    input  cache_pkg::l2_tag_t     tag,
    input  cache_pkg::l2_tag_t     tags_buf [`L2_WAYS],
    input  cache_pkg::line_state_t states_buf [`L2_WAYS],
    input  cache_pkg::l2_way_t     evict_way_buf,
    output logic                   tag_hit,
    output cache_pkg::l2_way_t     way_hit,
    output logic                   empty_way_found,
    output cache_pkg::l2_way_t     empty_way,
    output cache_pkg::l2_way_t     fill_way
);

    logic [`L2_WAYS-1:0] match_vec;
    logic                empty_found_next;
    cache_pkg::l2_way_t  way_hit_next;
    cache_pkg::l2_way_t  empty_way_next;
    cache_pkg::l2_way_t  fill_way_next;

    // downward scan so the lowest matching way wins.
    always_comb begin
        match_vec        = '0;
        way_hit_next     = '0;
        empty_found_next = 1'b0;
        empty_way_next   = '0;
        for (int i = `L2_WAYS-1; i >= 0; i--) begin
            if (tags_buf[i] == tag && states_buf[i] != `INVALID) begin
                match_vec[i] = 1'b1;
                way_hit_next = cache_pkg::l2_way_t'(i);
            end
            if (states_buf[i] == `INVALID) begin
                empty_found_next = 1'b1;
                empty_way_next   = cache_pkg::l2_way_t'(i);
            end
        end
    end

    // round-robin victim only when the set is full.
    assign fill_way_next = empty_found_next ? empty_way_next : evict_way_buf;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag_hit         <= 1'b0;
            way_hit         <= '0;
            empty_way_found <= 1'b0;
            empty_way       <= '0;
            fill_way        <= '0;
        end else if (lookup_en) begin
            tag_hit         <= |match_vec;
            way_hit         <= way_hit_next;
            empty_way_found <= empty_found_next;
            empty_way       <= empty_way_next;
            fill_way        <= fill_way_next;
        end
    end

    // a tag may live in only one way of a set.
    single_match: assert property (@(posedge clk) disable iff (!rst)
        lookup_en |-> $onehot0(match_vec))
        else $error("tag matches more than one way");

endmodule

//--- src/l2_ctrl.sv
// ********************
// one request at a time; requester holds adr, we and dat_w until ack.
// ********************
`timescale 1ns/1ns
`include "cache_settings.svh"

module l2_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  cache_pkg::l2_addr_t    adr,
    input  cache_pkg::l2_word_t    dat_w,
    output logic                   ack,
    output cache_pkg::l2_word_t    dat_r,
    output logic                   mem_cyc,
    output logic                   mem_stb,
    output logic                   mem_we,
    output cache_pkg::l2_addr_t    mem_adr,
    output cache_pkg::l2_word_t    mem_dat_w,
    input  logic                   mem_ack,
    input  cache_pkg::l2_word_t    mem_dat_r,
    input  logic                   tag_hit,
    input  cache_pkg::l2_way_t     way_hit,
    input  logic                   empty_way_found,
    input  cache_pkg::l2_way_t     fill_way,
    input  cache_pkg::l2_tag_t     tags_buf [`L2_WAYS],
    input  cache_pkg::line_state_t states_buf [`L2_WAYS],
    input  cache_pkg::l2_word_t    data_buf [`L2_WAYS],
    output logic                   rd_en,
    output cache_pkg::l2_set_t     set_idx,
    output logic                   wr_en,
    output cache_pkg::l2_way_t     wr_way,
    output cache_pkg::l2_tag_t     wr_tag,
    output cache_pkg::line_state_t wr_state,
    output cache_pkg::l2_word_t    wr_data,
    output logic                   advance_ptr,
    output logic                   lookup_en,
    output cache_pkg::l2_tag_t     lookup_tag
);

    cache_pkg::ctrl_state_t state;
    cache_pkg::ctrl_state_t state_next;
    cache_pkg::l2_tag_t     req_tag;
    logic victim_dirty;
    logic mem_done;
    logic start_wb;
    logic start_fill;
    logic hit_write;
    logic miss_install;
    logic fill_install;

    assign req_tag      = adr[31:`L2_SET_BITS+2];
    assign set_idx      = adr[`L2_SET_BITS+1:2];
    assign victim_dirty = states_buf[fill_way] == `DIRTY;
    assign mem_done     = mem_cyc && mem_ack;
    assign start_wb     = state == cache_pkg::decide && !tag_hit && victim_dirty;
    assign start_fill   = state == cache_pkg::fill && !mem_cyc;

    assign rd_en      = state == cache_pkg::read_set;
    assign lookup_en  = state == cache_pkg::lookup;
    assign lookup_tag = req_tag;
    assign ack        = state == cache_pkg::respond;

    // a write miss installs right away, or once the victim is written back.
    assign hit_write    = state == cache_pkg::decide && tag_hit && we;
    assign miss_install = we && !tag_hit &&
                          ((state == cache_pkg::decide && !victim_dirty) ||
                           (state == cache_pkg::write_back && mem_done));
    assign fill_install = state == cache_pkg::fill && mem_done;

    assign wr_en       = hit_write || miss_install || fill_install;
    assign wr_way      = hit_write ? way_hit : fill_way;
    assign wr_tag      = req_tag;
    assign wr_state    = fill_install ? `VALID : `DIRTY;
    assign wr_data     = fill_install ? mem_dat_r : dat_w;
    assign advance_ptr = (miss_install || fill_install) && !empty_way_found;

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::idle: if (cyc && stb) state_next = cache_pkg::read_set;
            cache_pkg::read_set: state_next = cache_pkg::lookup;
            cache_pkg::lookup: state_next = cache_pkg::decide;
            cache_pkg::decide: begin
                if (tag_hit || (we && !victim_dirty)) begin
                    state_next = cache_pkg::respond;
                end else if (victim_dirty) begin
                    state_next = cache_pkg::write_back;
                end else begin
                    state_next = cache_pkg::fill;
                end
            end
            cache_pkg::write_back: begin
                if (mem_done) state_next = we ? cache_pkg::respond : cache_pkg::fill;
            end
            cache_pkg::fill: if (mem_done) state_next = cache_pkg::respond;
            default: state_next = cache_pkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= cache_pkg::idle;
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            state <= state_next;
            // cyc drops for a cycle between write-back and fill.
            if (start_wb || start_fill) begin
                mem_cyc <= 1'b1;
                mem_stb <= 1'b1;
                mem_we  <= start_wb;
            end else if (mem_done) begin
                mem_cyc <= 1'b0;
                mem_stb <= 1'b0;
                mem_we  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit_write == 1'b0 && state == cache_pkg::decide && tag_hit) begin
            dat_r <= data_buf[way_hit];
        end
        if (fill_install) begin
            dat_r <= mem_dat_r;
        end
        // victim address rebuilt from its tag and the set index.
        if (start_wb) begin
            mem_adr   <= {tags_buf[fill_way], set_idx, 2'b00};
            mem_dat_w <= data_buf[fill_way];
        end else if (start_fill) begin
            mem_adr <= {adr[31:2], 2'b00};
        end
    end

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst)
        ack |-> cyc && stb)
        else $error("ack without an active request");

    // memory strobe only inside a cycle and only in the two memory phases.
    mem_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst)
        mem_stb |-> mem_cyc &&
                    (state == cache_pkg::write_back || state == cache_pkg::fill))
        else $error("mem_stb outside a memory phase");

endmodule

//--- src/l2_cache_top.sv
// ********************
// Wishbone classic on both ports, full-word accesses only.
// ********************
`timescale 1ns/1ns
`include "cache_settings.svh"

module l2_cache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  cache_pkg::l2_addr_t adr,
    input  cache_pkg::l2_word_t dat_w,
    output cache_pkg::l2_word_t dat_r,
    output logic                ack,
    output logic                mem_cyc,
    output logic                mem_stb,
    output logic                mem_we,
    output cache_pkg::l2_addr_t mem_adr,
    output cache_pkg::l2_word_t mem_dat_w,
    input  cache_pkg::l2_word_t mem_dat_r,
    input  logic                mem_ack
);

    cache_pkg::l2_tag_t     tags_buf [`L2_WAYS];
    cache_pkg::line_state_t states_buf [`L2_WAYS];
    cache_pkg::l2_word_t    data_buf [`L2_WAYS];
    cache_pkg::l2_way_t     evict_way_buf;
    logic                   rd_en;
    logic                   wr_en;
    logic                   advance_ptr;
    logic                   lookup_en;
    logic                   tag_hit;
    logic                   empty_way_found;
    cache_pkg::l2_set_t     set_idx;
    cache_pkg::l2_way_t     wr_way;
    cache_pkg::l2_way_t     way_hit;
    cache_pkg::l2_way_t     fill_way;
    cache_pkg::l2_tag_t     wr_tag;
    cache_pkg::l2_tag_t     lookup_tag;
    cache_pkg::line_state_t wr_state;
    cache_pkg::l2_word_t    wr_data;

    l2_tag_store tag_store_i (
        .clk(clk), .rst(rst),
        .rd_en(rd_en), .rd_set(set_idx),
        .wr_en(wr_en), .wr_set(set_idx), .wr_way(wr_way),
        .wr_tag(wr_tag), .wr_state(wr_state), .advance_ptr(advance_ptr),
        .tags_buf(tags_buf), .states_buf(states_buf), .evict_way_buf(evict_way_buf)
    );

    l2_data_store data_store_i (
        .clk(clk),
        .rd_en(rd_en), .rd_set(set_idx),
        .wr_en(wr_en), .wr_set(set_idx), .wr_way(wr_way), .wr_data(wr_data),
        .data_buf(data_buf)
    );

    // empty_way is left open; fill_way already folds it in.
    l2_lookup lookup_i (
        .clk(clk), .rst(rst),
        .lookup_en(lookup_en), .tag(lookup_tag),
        .tags_buf(tags_buf), .states_buf(states_buf), .evict_way_buf(evict_way_buf),
        .tag_hit(tag_hit), .way_hit(way_hit),
        .empty_way_found(empty_way_found), .empty_way(), .fill_way(fill_way)
    );

    l2_ctrl ctrl_i (
        .clk(clk), .rst(rst),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .ack(ack), .dat_r(dat_r),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we),
        .mem_adr(mem_adr), .mem_dat_w(mem_dat_w),
        .mem_ack(mem_ack), .mem_dat_r(mem_dat_r),
        .tag_hit(tag_hit), .way_hit(way_hit),
        .empty_way_found(empty_way_found), .fill_way(fill_way),
        .tags_buf(tags_buf), .states_buf(states_buf), .data_buf(data_buf),
        .rd_en(rd_en), .set_idx(set_idx),
        .wr_en(wr_en), .wr_way(wr_way), .wr_tag(wr_tag),
        .wr_state(wr_state), .wr_data(wr_data), .advance_ptr(advance_ptr),
        .lookup_en(lookup_en), .lookup_tag(lookup_tag)
    );

endmodule

//--- dv/l2_cache_tb.sv
// ********************
// memory answers after 0 to 3 wait states; the run stops at the first mismatch.
// ********************
`timescale 1ns/1ns
`include "cache_settings.svh"

module l2_cache_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int N_DIRECTED  = 10;
    localparam int N_RANDOM    = 300;
    localparam int MAX_WAIT    = 3;
    localparam int REQ_CYCLES  = 10 + 2 * (MAX_WAIT + 4);
    localparam int WATCHDOG_NS = ((N_DIRECTED + N_RANDOM) * REQ_CYCLES + 50) * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h70ba68ec;

    logic                clk = 1'b0;
    logic                rst;
    logic                cyc;
    logic                stb;
    logic                we;
    cache_pkg::l2_addr_t adr;
    cache_pkg::l2_word_t dat_w;
    cache_pkg::l2_word_t dat_r;
    logic                ack;
    logic                mem_cyc;
    logic                mem_stb;
    logic                mem_we;
    cache_pkg::l2_addr_t mem_adr;
    cache_pkg::l2_word_t mem_dat_w;
    cache_pkg::l2_word_t mem_dat_r = '0;
    logic                mem_ack = 1'b0;

    // memory model state and the memory cycles the reference model expects.
    cache_pkg::l2_word_t mem_words [cache_pkg::l2_addr_t];
    logic                mem_busy = 1'b0;
    int                  wait_left = 0;
    logic [31:0]         mem_rng = SEED;
    int                  mem_reads_seen = 0;
    int                  mem_writes_seen = 0;
    logic                exp_we_q [$];
    cache_pkg::l2_addr_t exp_adr_q [$];
    cache_pkg::l2_word_t exp_dat_q [$];

    // reference model: flat golden memory plus a shadow of the tag store.
    cache_pkg::l2_word_t    golden_mem [cache_pkg::l2_addr_t];
    cache_pkg::l2_tag_t     sh_tag [`L2_SETS][`L2_WAYS];
    cache_pkg::line_state_t sh_state [`L2_SETS][`L2_WAYS];
    cache_pkg::l2_way_t     sh_ptr [`L2_SETS];
    logic [31:0]            stim_rng;
    int                     last_reads;
    int                     last_writes;
    int                     last_latency;

    l2_cache_top dut_i (
        .clk(clk), .rst(rst),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
        .dat_r(dat_r), .ack(ack),
        .mem_cyc(mem_cyc), .mem_stb(mem_stb), .mem_we(mem_we),
        .mem_adr(mem_adr), .mem_dat_w(mem_dat_w),
        .mem_dat_r(mem_dat_r), .mem_ack(mem_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // contents of a word nobody has written.
    function automatic cache_pkg::l2_word_t init_word(input cache_pkg::l2_addr_t a);
        return (a * 32'h9e3779b1) ^ 32'h5a5a0ff0;
    endfunction

    function automatic cache_pkg::l2_word_t golden_read(input cache_pkg::l2_addr_t a);
        if (golden_mem.exists(a)) begin
            return golden_mem[a];
        end
        return init_word(a);
    endfunction

    function automatic cache_pkg::l2_addr_t make_addr(input int tag, input int set);
        return {cache_pkg::l2_tag_t'(tag), cache_pkg::l2_set_t'(set), 2'b00};
    endfunction

    // lowest invalid way first, else the per-set round-robin pointer.
    function automatic void ref_access(input logic req_we, input cache_pkg::l2_addr_t a,
                                       input cache_pkg::l2_word_t d, output logic hit,
                                       output logic wb, output cache_pkg::l2_addr_t wb_adr,
                                       output cache_pkg::l2_word_t wb_dat,
                                       output cache_pkg::l2_word_t rd_exp);
        cache_pkg::l2_set_t set;
        cache_pkg::l2_tag_t tag;
        cache_pkg::l2_way_t way;
        logic               found_empty;
        set = a[`L2_SET_BITS+1:2];
        tag = a[31:`L2_SET_BITS+2];
        hit = 1'b0;
        wb = 1'b0;
        wb_adr = '0;
        wb_dat = '0;
        way = '0;
        found_empty = 1'b0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (!hit && sh_state[set][w] != `INVALID && sh_tag[set][w] == tag) begin
                hit = 1'b1;
                way = cache_pkg::l2_way_t'(w);
            end
        end
        if (!hit) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (!found_empty && sh_state[set][w] == `INVALID) begin
                    found_empty = 1'b1;
                    way = cache_pkg::l2_way_t'(w);
                end
            end
            if (!found_empty) begin
                way = sh_ptr[set];
                sh_ptr[set] = sh_ptr[set] + 2'd1;
            end
            wb = sh_state[set][way] == `DIRTY;
            wb_adr = {sh_tag[set][way], set, 2'b00};
            wb_dat = golden_read(wb_adr);
            sh_tag[set][way] = tag;
            sh_state[set][way] = req_we ? `DIRTY : `VALID;
        end else if (req_we) begin
            sh_state[set][way] = `DIRTY;
        end
        rd_exp = golden_read(a);
        if (req_we) begin
            golden_mem[a] = d;
        end
    endfunction

    task automatic stop_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cache_pkg::l2_word_t got,
                              input cache_pkg::l2_word_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::l2_addr_t got,
                              input cache_pkg::l2_addr_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic serve_memory_cycle();
        logic                exp_we;
        cache_pkg::l2_addr_t exp_adr;
        cache_pkg::l2_word_t exp_dat;
        if (exp_we_q.size() == 0) begin
            $display("error at %0t ns: memory cycle to %h when none was expected",
                     $time, mem_adr);
            stop_run();
        end else begin
            exp_we  = exp_we_q.pop_front();
            exp_adr = exp_adr_q.pop_front();
            exp_dat = exp_dat_q.pop_front();
            check_flag("mem_we", mem_we, exp_we);
            check_addr("mem_adr", mem_adr, exp_adr);
            if (mem_we) begin
                check_word("mem_dat_w", mem_dat_w, exp_dat);
                mem_words[mem_adr] = mem_dat_w;
                mem_writes_seen++;
            end else begin
                mem_dat_r <= mem_words.exists(mem_adr) ? mem_words[mem_adr]
                                                       : init_word(mem_adr);
                mem_reads_seen++;
            end
        end
    endtask

    // Wishbone memory; each cycle is compared with the expected queue.
    always @(posedge clk) begin
        if (mem_ack) begin
            mem_ack <= 1'b0;
        end else if (mem_cyc && mem_stb) begin
            if (!mem_busy) begin
                mem_rng   = lcg_step(mem_rng);
                wait_left = int'(mem_rng[31:16]) % (MAX_WAIT + 1);
                mem_busy  = 1'b1;
            end
            if (wait_left == 0) begin
                serve_memory_cycle();
                mem_busy = 1'b0;
                mem_ack <= 1'b1;
            end else begin
                wait_left--;
            end
        end
    end

    task automatic run_request(input logic req_we, input cache_pkg::l2_addr_t a,
                               input cache_pkg::l2_word_t d);
        logic                hit;
        logic                wb;
        cache_pkg::l2_addr_t wb_adr;
        cache_pkg::l2_word_t wb_dat;
        cache_pkg::l2_word_t rd_exp;
        int                  edges;
        int                  reads_before;
        int                  writes_before;
        ref_access(req_we, a, d, hit, wb, wb_adr, wb_dat, rd_exp);
        if (wb) begin
            exp_we_q.push_back(1'b1);
            exp_adr_q.push_back(wb_adr);
            exp_dat_q.push_back(wb_dat);
        end
        if (!hit && !req_we) begin
            exp_we_q.push_back(1'b0);
            exp_adr_q.push_back(a);
            exp_dat_q.push_back('0);
        end
        reads_before = mem_reads_seen;
        writes_before = mem_writes_seen;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= req_we;
        adr   <= a;
        dat_w <= d;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
        end while (!ack);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        // the first edge counted is the one that samples the request.
        last_latency = edges - 1;
        last_reads = mem_reads_seen - reads_before;
        last_writes = mem_writes_seen - writes_before;
        if (!req_we) begin
            check_word("dat_r", dat_r, rd_exp);
        end
        if (exp_we_q.size() != 0) begin
            $display("error at %0t ns: request to %h acknowledged before its memory cycles",
                     $time, a);
            stop_run();
        end
    endtask

    initial begin
        logic r_we;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        rst = 1'b0;
        stim_rng = SEED;
        for (int s = 0; s < `L2_SETS; s++) begin
            sh_ptr[s] = '0;
            for (int w = 0; w < `L2_WAYS; w++) begin
                sh_tag[s][w] = '0;
                sh_state[s][w] = `INVALID;
            end
        end
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            check_flag("ack", ack, 1'b0);
            check_flag("mem_cyc", mem_cyc, 1'b0);
            check_flag("mem_stb", mem_stb, 1'b0);
        end

        run_request(1'b0, make_addr(117, 5), '0);
        check_count("memory reads on first read", last_reads, 1);
        check_count("memory writes on first read", last_writes, 0);
        run_request(1'b0, make_addr(117, 5), '0);
        check_count("memory cycles on repeated read", last_reads + last_writes, 0);
        check_count("hit ack latency", last_latency, 4);

        run_request(1'b1, make_addr(144, 6), 32'hcafe0001);
        check_count("memory cycles on write miss", last_reads + last_writes, 0);
        run_request(1'b0, make_addr(144, 6), '0);
        check_count("memory cycles on read after write", last_reads + last_writes, 0);

        // five dirty tags in set 3 push the oldest one out.
        for (int t = 20; t < 25; t++) begin
            run_request(1'b1, make_addr(t, 3), 32'hd0d00000 + t);
        end
        check_count("write-backs on fifth tag", last_writes, 1);
        run_request(1'b0, make_addr(20, 3), '0);
        check_count("fills on evicted address", last_reads, 1);

        for (int i = 0; i < N_RANDOM; i++) begin
            stim_rng = lcg_step(stim_rng);
            r_we = stim_rng[31];
            adr_pick: begin
                cache_pkg::l2_addr_t a;
                a = make_addr(int'(stim_rng[27:24]), int'(stim_rng[21:20]));
                stim_rng = lcg_step(stim_rng);
                run_request(r_we, a, stim_rng);
            end
        end

        repeat (2) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("error at %0t ns: watchdog expired, a handshake never completed", $time);
        stop_run();
    end

endmodule

//--- vlog.f
+incdir+src
src/cache_pkg.sv
src/l2_tag_store.sv
src/l2_data_store.sv
src/l2_lookup.sv
src/l2_ctrl.sv
src/l2_cache_top.sv
dv/l2_cache_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module l2_cache_tb -o l2_cache_sim

out=$(./obj_dir/l2_cache_sim 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
